// File: list.f
rtl/exe_pkg.sv
rtl/wb_map_pkg.sv
rtl/adder64.sv
rtl/operand_select.sv
rtl/exe_stage.sv
rtl/forward_unit.sv
rtl/exe_regs.sv
rtl/exe_top.sv
tests/exe_tb_assert.sv
tests/exe_tb.sv

// File: tests/exe_tb.sv
module exe_tb import exe_pkg::*, wb_map_pkg::*; ();

	// roughly twice the cycles that all tests take
	localparam int max_cycles = 4000;

	logic            clk;
	logic            rst;
	logic            wb_cyc;
	logic            wb_stb;
	logic            wb_we;
	wb_reg_t         wb_adr;
	logic [xlen-1:0] wb_wdata;
	logic            wb_ack;
	logic [xlen-1:0] wb_rdata;
	integer          seed;
	int              cycles = 0;

	// reference model state
	logic [xlen-1:0] m_rs1 = '0;
	logic [xlen-1:0] m_rs2 = '0;
	logic [xlen-1:0] m_pc = '0;
	logic [xlen-1:0] m_imm = '0;
	logic [xlen-1:0] m_cmd = '0;
	logic            me_v = 1'b0;
	logic            wb_v = 1'b0;
	logic [4:0]      me_rd = '0;
	logic [4:0]      wb_rd = '0;
	logic [xlen-1:0] me_res = '0;
	logic [xlen-1:0] wb_res = '0;

	exe_top i_exe_top (
		.clk      (clk),
		.rst      (rst),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_wdata (wb_wdata),
		.wb_ack   (wb_ack),
		.wb_rdata (wb_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (i_exe_top.i_exe_regs.i_exe_tb_assert.err_count != 0) begin
			$display("Checks failed");
			$fatal(1, "bus assertions reported errors");
		end else if (cycles >= max_cycles) begin
			$display("timeout: the bus stopped answering after %0d cycles", cycles);
			$display("Checks failed");
			$fatal(1, "run stopped by timeout");
		end
	end

	task automatic check_word(input string name, input logic [xlen-1:0] exp,
			input logic [xlen-1:0] act);
		if (act !== exp) begin
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
			$display("Checks failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
			$display("Checks failed");
			$fatal(1, "flag mismatch");
		end
	endtask

	// one classic transfer, held until ack
	task automatic bus_cycle(input logic we, input wb_reg_t adr, input logic [xlen-1:0] wdata,
			output logic [xlen-1:0] rdata);
		@(posedge clk);
		#10;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_wdata = wdata;
		@(posedge clk);
		#1;
		while (!wb_ack) begin
			@(posedge clk);
			#1;
		end
		rdata = wb_rdata;
		#9;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_write(input wb_reg_t adr, input logic [xlen-1:0] data);
		logic [xlen-1:0] unused;
		bus_cycle(1'b1, adr, data, unused);
	endtask

	task automatic wb_read(input wb_reg_t adr, output logic [xlen-1:0] data);
		bus_cycle(1'b0, adr, '0, data);
	endtask

	function automatic logic [xlen-1:0] rand64();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic logic [xlen-1:0] sign_extend_word(input logic [31:0] w);
		return {{(xlen-32){w[31]}}, w};
	endfunction

	// newest history entry first, x0 is never taken from history
	function automatic logic [xlen-1:0] src_value(input logic [4:0] idx,
			input logic [xlen-1:0] reg_val);
		if (me_v && me_rd != 5'd0 && me_rd == idx)
			return me_res;
		if (wb_v && wb_rd != 5'd0 && wb_rd == idx)
			return wb_res;
		return reg_val;
	endfunction

	function automatic logic [xlen-1:0] exp_rs1();
		return src_value(m_cmd[cmd_rs1_hi:cmd_rs1_lo], m_rs1);
	endfunction

	function automatic logic [xlen-1:0] exp_op1();
		return m_cmd[cmd_op1_sel] ? m_pc : exp_rs1();
	endfunction

	function automatic logic [xlen-1:0] exp_op2();
		case (op2_sel_t'(m_cmd[cmd_op2_sel_hi:cmd_op2_sel_lo]))
			op2_imm:  return m_imm;
			op2_four: return 64'd4;
			default:  return src_value(m_cmd[cmd_rs2_hi:cmd_rs2_lo], m_rs2);
		endcase
	endfunction

	function automatic logic [xlen-1:0] exp_result();
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		logic [31:0]     w;
		a = exp_op1();
		b = exp_op2();
		case (alu_op_t'(m_cmd[cmd_alu_op_hi:cmd_alu_op_lo]))
			alu_add:  return a + b;
			alu_sub:  return a - b;
			alu_addw: w = a[31:0] + b[31:0];
			alu_subw: w = a[31:0] - b[31:0];
			alu_slt:  return xlen'($signed(a) < $signed(b));
			alu_sltu: return xlen'(a < b);
			alu_xor:  return a ^ b;
			alu_or:   return a | b;
			alu_and:  return a & b;
			alu_sll:  return a << b[5:0];
			alu_srl:  return a >> b[5:0];
			alu_sra:  return $signed(a) >>> b[5:0];
			alu_sllw: w = a[31:0] << b[4:0];
			alu_srlw: w = a[31:0] >> b[4:0];
			alu_sraw: w = $signed(a[31:0]) >>> b[4:0];
			alu_lui:  return b;
			default:  return '0;
		endcase
		return sign_extend_word(w);
	endfunction

	function automatic logic exp_flag();
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		a = exp_op1();
		b = exp_op2();
		case (alu_op_t'(m_cmd[cmd_alu_op_hi:cmd_alu_op_lo]))
			alu_beq:  return a == b;
			alu_bne:  return a != b;
			alu_blt:  return $signed(a) < $signed(b);
			alu_bge:  return $signed(a) >= $signed(b);
			alu_bltu: return a < b;
			alu_bgeu: return a >= b;
			default:  return 1'b0;
		endcase
	endfunction

	function automatic logic [xlen-1:0] exp_target();
		if (m_cmd[cmd_pc_src])
			return (exp_rs1() + m_imm) & ~64'd1;
		return m_pc + m_imm;
	endfunction

	// bus write that also updates the model, a cmd write retires the current result
	task automatic write_reg(input wb_reg_t adr, input logic [xlen-1:0] data);
		logic [xlen-1:0] retired;
		wb_write(adr, data);
		case (adr)
			reg_rs1_val: m_rs1 = data;
			reg_rs2_val: m_rs2 = data;
			reg_pc_val:  m_pc = data;
			reg_imm_val: m_imm = data;
			reg_cmd: begin
				retired = exp_result();
				wb_v = me_v;
				wb_rd = me_rd;
				wb_res = me_res;
				me_v = 1'b1;
				me_rd = m_cmd[cmd_rd_hi:cmd_rd_lo];
				me_res = retired;
				m_cmd = data;
			end
			default: ;
		endcase
	endtask

	task automatic set_operands(input logic [xlen-1:0] a, input logic [xlen-1:0] b,
			input logic [xlen-1:0] p, input logic [xlen-1:0] i);
		write_reg(reg_rs1_val, a);
		write_reg(reg_rs2_val, b);
		write_reg(reg_pc_val, p);
		write_reg(reg_imm_val, i);
	endtask

	task automatic issue_cmd(input alu_op_t op, input op1_sel_t o1, input op2_sel_t o2,
			input logic psrc, input logic [4:0] r1, input logic [4:0] r2, input logic [4:0] rd);
		logic [xlen-1:0] c;
		c = '0;
		c[cmd_alu_op_hi:cmd_alu_op_lo] = op;
		c[cmd_op1_sel] = o1;
		c[cmd_op2_sel_hi:cmd_op2_sel_lo] = o2;
		c[cmd_pc_src] = psrc;
		c[cmd_rs1_hi:cmd_rs1_lo] = r1;
		c[cmd_rs2_hi:cmd_rs2_lo] = r2;
		c[cmd_rd_hi:cmd_rd_lo] = rd;
		write_reg(reg_cmd, c);
	endtask

	task automatic check_outputs();
		logic [xlen-1:0] d;
		wb_read(reg_result, d);
		check_word("result", exp_result(), d);
		wb_read(reg_target, d);
		check_word("target", exp_target(), d);
		wb_read(reg_flags, d);
		check_flag("b_flag", exp_flag(), d[0]);
	endtask

	task automatic test_reset_values();
		logic [xlen-1:0] d;
		logic [xlen-1:0] v;
		check_outputs();
		for (int a = 0; a <= 4; a++) begin
			wb_read(wb_reg_t'(a), d);
			check_word("reset readback", '0, d);
		end
		for (int a = 0; a < 4; a++) begin
			v = rand64();
			write_reg(wb_reg_t'(a), v);
			wb_read(wb_reg_t'(a), d);
			check_word("readback", v, d);
		end
	endtask

	// rd index 0 keeps forwarding out of these
	task automatic test_alu_ops();
		alu_op_t         plain_ops[8] = '{alu_add, alu_addw, alu_sub, alu_subw,
			alu_xor, alu_or, alu_and, alu_lui};
		alu_op_t         shift_ops[6] = '{alu_sll, alu_srl, alu_sra, alu_sllw, alu_srlw, alu_sraw};
		logic [5:0]      shamts[4] = '{6'd0, 6'd31, 6'd32, 6'd63};
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		for (int i = 0; i < 8; i++) begin
			for (int k = 0; k < 5; k++) begin
				a = (k == 0) ? 64'h7fff_ffff_ffff_ffff : (k == 1) ? 64'h7fff_ffff : rand64();
				b = (k < 2) ? 64'd1 : rand64();
				set_operands(a, b, rand64(), b);
				issue_cmd(plain_ops[i], op1_rs1, (plain_ops[i] == alu_lui) ? op2_imm : op2_rs2,
					1'b0, 5'd1, 5'd2, 5'd0);
				check_outputs();
			end
		end
		for (int i = 0; i < 6; i++) begin
			for (int k = 0; k < 5; k++) begin
				// negative in both widths for the arithmetic shifts
				a = (k < 4) ? (rand64() | 64'h8000_0000_8000_0000) : rand64();
				b = (k < 4) ? xlen'(shamts[k]) : rand64();
				set_operands(a, b, rand64(), rand64());
				issue_cmd(shift_ops[i], op1_rs1, op2_rs2, 1'b0, 5'd1, 5'd2, 5'd0);
				check_outputs();
			end
		end
	endtask

	task automatic test_compares();
		alu_op_t         cmp_ops[8] = '{alu_slt, alu_sltu, alu_beq, alu_bne,
			alu_blt, alu_bge, alu_bltu, alu_bgeu};
		logic [xlen-1:0] lhs[3] = '{64'h1234, 64'hffff_ffff_ffff_ffff, 64'h7fff_ffff_ffff_ffff};
		logic [xlen-1:0] rhs[3] = '{64'h1234, 64'h1, 64'h8000_0000_0000_0000};
		for (int i = 0; i < 8; i++) begin
			for (int k = 0; k < 6; k++) begin
				if (k < 3)
					set_operands(lhs[k], rhs[k], rand64(), rand64() | 64'd1);
				else
					set_operands(rhs[k-3], lhs[k-3], rand64(), rand64() | 64'd1);
				issue_cmd(cmp_ops[i], op1_rs1, op2_rs2, k[0], 5'd1, 5'd2, 5'd0);
				check_outputs();
			end
		end
		// jal link value
		set_operands(rand64(), rand64(), rand64(), rand64());
		issue_cmd(alu_add, op1_pc, op2_four, 1'b0, 5'd1, 5'd2, 5'd0);
		check_outputs();
	endtask

	task automatic test_forwarding();
		set_operands(64'd10, 64'd20, rand64(), 64'h41);
		issue_cmd(alu_add, op1_rs1, op2_rs2, 1'b0, 5'd1, 5'd2, 5'd5);
		check_outputs();
		// rs1 from the previous result, also as jalr base
		issue_cmd(alu_add, op1_rs1, op2_rs2, 1'b1, 5'd5, 5'd2, 5'd6);
		check_outputs();
		// rs1 from two back, rs2 from the previous one
		issue_cmd(alu_add, op1_rs1, op2_rs2, 1'b0, 5'd5, 5'd6, 5'd7);
		check_outputs();
		issue_cmd(alu_sub, op1_rs1, op2_rs2, 1'b0, 5'd1, 5'd2, 5'd9);
		issue_cmd(alu_xor, op1_rs1, op2_rs2, 1'b0, 5'd1, 5'd2, 5'd9);
		// both slots hold x9, newest wins
		issue_cmd(alu_add, op1_rs1, op2_rs2, 1'b1, 5'd9, 5'd9, 5'd3);
		check_outputs();
	endtask

	// the x0 result differs from rs1 + rs2 so a wrong forward shows
	task automatic test_x0_and_unrelated();
		set_operands(64'd7, 64'd9, rand64(), rand64());
		issue_cmd(alu_sub, op1_rs1, op2_rs2, 1'b0, 5'd1, 5'd2, 5'd0);
		issue_cmd(alu_add, op1_rs1, op2_rs2, 1'b0, 5'd0, 5'd0, 5'd12);
		check_outputs();
		issue_cmd(alu_sub, op1_rs1, op2_rs2, 1'b1, 5'd0, 5'd13, 5'd0);
		check_outputs();
	endtask

	initial begin
		seed = 7;
		rst = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = reg_rs1_val;
		wb_wdata = '0;
		repeat (5) @(posedge clk);
		#10;
		rst = 1'b0;
		test_reset_values();
		test_alu_ops();
		test_compares();
		test_forwarding();
		test_x0_and_unrelated();
		if (i_exe_top.i_exe_regs.i_exe_tb_assert.err_count == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			$display("Checks failed");
			$fatal(1, "bus assertions reported errors");
		end
	end

endmodule

// File: tests/exe_tb_assert.sv
module exe_tb_assert import exe_pkg::*; (
	input logic            clk,
	input logic            rst,
	input logic            wb_cyc,
	input logic            wb_stb,
	input logic            wb_ack,
	input logic [xlen-1:0] wb_rdata
);

	// read by the testbench at the end of the run
	int err_count = 0;

	// ack only answers a sampled request
	ack_after_req: assert property (@(posedge clk) disable iff (rst)
		$rose(wb_ack) |-> $past(wb_cyc && wb_stb))
		else begin
			err_count++;
			$error("ack raised without a request");
		end

	// single-cycle ack
	ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
		wb_ack |=> !wb_ack)
		else begin
			err_count++;
			$error("ack held for two cycles");
		end

	rdata_known: assert property (@(posedge clk) disable iff (rst)
		wb_ack |-> !$isunknown(wb_rdata))
		else begin
			err_count++;
			$error("read data has unknown bits during ack");
		end

endmodule

bind exe_regs exe_tb_assert i_exe_tb_assert (
	.clk      (clk),
	.rst      (rst),
	.wb_cyc   (wb_cyc),
	.wb_stb   (wb_stb),
	.wb_ack   (wb_ack),
	.wb_rdata (wb_rdata)
);

// File: rtl/exe_top.sv
module exe_top import exe_pkg::*, wb_map_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            wb_cyc,
	input  logic            wb_stb,
	input  logic            wb_we,
	input  wb_reg_t         wb_adr,
	input  logic [xlen-1:0] wb_wdata,
	output logic            wb_ack,
	output logic [xlen-1:0] wb_rdata
);

	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] imm;
	alu_op_t         alu_op;
	op1_sel_t        op1_sel;
	op2_sel_t        op2_sel;
	logic            pc_src;
	logic [4:0]      rs1_idx;
	logic [4:0]      rs2_idx;
	logic [4:0]      rd_idx;
	logic            issue;
	fwd_src_t        rs1_src;
	fwd_src_t        rs2_src;
	logic [xlen-1:0] me_result;
	logic [xlen-1:0] wb_result;
	logic [xlen-1:0] alu_result;
	logic [xlen-1:0] target_pc;
	logic            b_flag;

	exe_regs i_exe_regs (
		.clk        (clk),
		.rst        (rst),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_wdata   (wb_wdata),
		.wb_ack     (wb_ack),
		.wb_rdata   (wb_rdata),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.pc         (pc),
		.imm        (imm),
		.alu_op     (alu_op),
		.op1_sel    (op1_sel),
		.op2_sel    (op2_sel),
		.pc_src     (pc_src),
		.rs1_idx    (rs1_idx),
		.rs2_idx    (rs2_idx),
		.rd_idx     (rd_idx),
		.issue      (issue),
		.alu_result (alu_result),
		.target_pc  (target_pc),
		.b_flag     (b_flag)
	);

	forward_unit i_forward_unit (
		.clk        (clk),
		.rst        (rst),
		.issue      (issue),
		.rs1_idx    (rs1_idx),
		.rs2_idx    (rs2_idx),
		.rd_idx     (rd_idx),
		.alu_result (alu_result),
		.rs1_src    (rs1_src),
		.rs2_src    (rs2_src),
		.me_result  (me_result),
		.wb_result  (wb_result)
	);

	exe_stage i_exe_stage (
		.rst        (rst),
		.alu_op     (alu_op),
		.pc_src     (pc_src),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.me_result  (me_result),
		.wb_result  (wb_result),
		.pc         (pc),
		.imm        (imm),
		.rs1_src    (rs1_src),
		.rs2_src    (rs2_src),
		.op1_sel    (op1_sel),
		.op2_sel    (op2_sel),
		.alu_result (alu_result),
		.target_pc  (target_pc),
		.b_flag     (b_flag)
	);

endmodule

// File: rtl/exe_regs.sv
module exe_regs import exe_pkg::*, wb_map_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            wb_cyc,
	input  logic            wb_stb,
	input  logic            wb_we,
	input  wb_reg_t         wb_adr,
	input  logic [xlen-1:0] wb_wdata,
	output logic            wb_ack,
	output logic [xlen-1:0] wb_rdata,
	output logic [xlen-1:0] rs1_data,
	output logic [xlen-1:0] rs2_data,
	output logic [xlen-1:0] pc,
	output logic [xlen-1:0] imm,
	output alu_op_t         alu_op,
	output op1_sel_t        op1_sel,
	output op2_sel_t        op2_sel,
	output logic            pc_src,
	output logic [4:0]      rs1_idx,
	output logic [4:0]      rs2_idx,
	output logic [4:0]      rd_idx,
	output logic            issue,
	input  logic [xlen-1:0] alu_result,
	input  logic [xlen-1:0] target_pc,
	input  logic            b_flag
);

	logic            req;
	logic [xlen-1:0] cmd_q;
	logic [xlen-1:0] rd_mux;

	// new request, not the cycle already being acked
	assign req = wb_cyc && wb_stb && !wb_ack;

	// history shifts on the same edge that takes the new command
	assign issue = req && wb_we && (wb_adr == reg_cmd);

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_ack   <= 1'b0;
			rs1_data <= '0;
			rs2_data <= '0;
			pc       <= '0;
			imm      <= '0;
			cmd_q    <= '0;
		end else begin
			wb_ack <= req;
			if (req && wb_we) begin
				case (wb_adr)
					reg_rs1_val: rs1_data <= wb_wdata;
					reg_rs2_val: rs2_data <= wb_wdata;
					reg_pc_val:  pc       <= wb_wdata;
					reg_imm_val: imm      <= wb_wdata;
					reg_cmd:     cmd_q    <= wb_wdata;
					default:     ;
				endcase
			end
		end
	end

	always_comb begin
		case (wb_adr)
			reg_rs1_val: rd_mux = rs1_data;
			reg_rs2_val: rd_mux = rs2_data;
			reg_pc_val:  rd_mux = pc;
			reg_imm_val: rd_mux = imm;
			reg_cmd:     rd_mux = cmd_q;
			reg_result:  rd_mux = alu_result;
			reg_target:  rd_mux = target_pc;
			reg_flags:   rd_mux = {{(xlen-1){1'b0}}, b_flag};
			default:     rd_mux = '0;
		endcase
	end

	// held through the ack cycle
	always_ff @(posedge clk) begin
		if (req)
			wb_rdata <= rd_mux;
	end

	// command fields
	assign alu_op  = alu_op_t'(cmd_q[cmd_alu_op_hi:cmd_alu_op_lo]);
	assign op1_sel = op1_sel_t'(cmd_q[cmd_op1_sel]);
	assign op2_sel = op2_sel_t'(cmd_q[cmd_op2_sel_hi:cmd_op2_sel_lo]);
	assign pc_src  = cmd_q[cmd_pc_src];
	assign rs1_idx = cmd_q[cmd_rs1_hi:cmd_rs1_lo];
	assign rs2_idx = cmd_q[cmd_rs2_hi:cmd_rs2_lo];
	assign rd_idx  = cmd_q[cmd_rd_hi:cmd_rd_lo];

endmodule

// File: rtl/forward_unit.sv
module forward_unit import exe_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            issue,
	input  logic [4:0]      rs1_idx,
	input  logic [4:0]      rs2_idx,
	input  logic [4:0]      rd_idx,
	input  logic [xlen-1:0] alu_result,
	output fwd_src_t        rs1_src,
	output fwd_src_t        rs2_src,
	output logic [xlen-1:0] me_result,
	output logic [xlen-1:0] wb_result
);

	logic       me_valid;
	logic       wb_valid;
	logic [4:0] me_rd;
	logic [4:0] wb_rd;

	// retire the current instruction as a new command is accepted
	always_ff @(posedge clk) begin
		if (rst) begin
			me_valid <= 1'b0;
			wb_valid <= 1'b0;
			me_rd    <= '0;
			wb_rd    <= '0;
		end else if (issue) begin
			me_valid <= 1'b1;
			me_rd    <= rd_idx;
			wb_valid <= me_valid;
			wb_rd    <= me_rd;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			me_result <= alu_result;
			wb_result <= me_result;
		end
	end

	// newest match wins, x0 never matches
	function automatic fwd_src_t pick(input logic [4:0] idx);
		if (me_valid && me_rd != '0 && me_rd == idx)
			return fwd_me;
		if (wb_valid && wb_rd != '0 && wb_rd == idx)
			return fwd_wb;
		return fwd_reg;
	endfunction

	assign rs1_src = pick(rs1_idx);
	assign rs2_src = pick(rs2_idx);

endmodule

// File: rtl/exe_stage.sv
module exe_stage import exe_pkg::*; (
	input  logic            rst,
	input  alu_op_t         alu_op,
	input  logic            pc_src,
	input  logic [xlen-1:0] rs1_data,
	input  logic [xlen-1:0] rs2_data,
	input  logic [xlen-1:0] me_result,
	input  logic [xlen-1:0] wb_result,
	input  logic [xlen-1:0] pc,
	input  logic [xlen-1:0] imm,
	input  fwd_src_t        rs1_src,
	input  fwd_src_t        rs2_src,
	input  op1_sel_t        op1_sel,
	input  op2_sel_t        op2_sel,
	output logic [xlen-1:0] alu_result,
	output logic [xlen-1:0] target_pc,
	output logic            b_flag
);

	logic [xlen-1:0] new_rs1;
	logic [xlen-1:0] op1;
	logic [xlen-1:0] op2;
	logic            sub_mode;
	logic [xlen-1:0] add_op2;
	logic [xlen-1:0] sum;
	logic            zero;
	logic            sign;
	logic            overflow;
	logic            carry;
	logic            less;
	logic [xlen-1:0] sll_res;
	logic [xlen-1:0] srl_res;
	logic [xlen-1:0] sra_res;
	logic [31:0]     sllw_res;
	logic [31:0]     srlw_res;
	logic [31:0]     sraw_res;
	logic [xlen-1:0] tgt_base;
	logic [xlen-1:0] tgt_sum;

	function automatic logic [xlen-1:0] sext32(input logic [31:0] w);
		return {{(xlen-32){w[31]}}, w};
	endfunction

	operand_select i_operand_select (
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.me_result (me_result),
		.wb_result (wb_result),
		.pc        (pc),
		.imm       (imm),
		.rs1_src   (rs1_src),
		.rs2_src   (rs2_src),
		.op1_sel   (op1_sel),
		.op2_sel   (op2_sel),
		.new_rs1   (new_rs1),
		.new_rs2   (),
		.op1       (op1),
		.op2       (op2)
	);

	// compares and branches run as op1 - op2
	always_comb begin
		case (alu_op)
			alu_sub, alu_subw, alu_slt, alu_sltu,
			alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu: sub_mode = 1'b1;
			default: sub_mode = 1'b0;
		endcase
	end

	assign add_op2 = sub_mode ? ~op2 : op2;

	adder64 i_alu_adder (
		.op1      (op1),
		.op2      (add_op2),
		.cin      (sub_mode),
		.result   (sum),
		.zero     (zero),
		.sign     (sign),
		.overflow (overflow),
		.carry    (carry)
	);

	assign less = sign ^ overflow;

	// word shifts use 5-bit amounts
	assign sll_res  = op1 << op2[5:0];
	assign srl_res  = op1 >> op2[5:0];
	assign sra_res  = $signed(op1) >>> op2[5:0];
	assign sllw_res = op1[31:0] << op2[4:0];
	assign srlw_res = op1[31:0] >> op2[4:0];
	assign sraw_res = $signed(op1[31:0]) >>> op2[4:0];

	always_comb begin
		alu_result = '0;
		if (!rst) begin
			case (alu_op)
				alu_add, alu_sub:   alu_result = sum;
				alu_addw, alu_subw: alu_result = sext32(sum[31:0]);
				alu_slt:  alu_result = {{(xlen-1){1'b0}}, less};
				alu_sltu: alu_result = {{(xlen-1){1'b0}}, carry};
				alu_xor:  alu_result = op1 ^ op2;
				alu_or:   alu_result = op1 | op2;
				alu_and:  alu_result = op1 & op2;
				alu_sll:  alu_result = sll_res;
				alu_srl:  alu_result = srl_res;
				alu_sra:  alu_result = sra_res;
				alu_sllw: alu_result = sext32(sllw_res);
				alu_srlw: alu_result = sext32(srlw_res);
				alu_sraw: alu_result = sext32(sraw_res);
				alu_lui:  alu_result = op2;
				default:  alu_result = '0;
			endcase
		end
	end

	always_comb begin
		b_flag = 1'b0;
		if (!rst) begin
			case (alu_op)
				alu_beq:  b_flag = zero;
				alu_bne:  b_flag = ~zero;
				alu_blt:  b_flag = less;
				alu_bge:  b_flag = ~less;
				alu_bltu: b_flag = carry;
				alu_bgeu: b_flag = ~carry;
				default:  b_flag = 1'b0;
			endcase
		end
	end

	// jalr bases on rs1, branches and jal on pc
	assign tgt_base = pc_src ? new_rs1 : pc;

	adder64 i_tgt_adder (
		.op1      (tgt_base),
		.op2      (imm),
		.cin      (1'b0),
		.result   (tgt_sum),
		.zero     (),
		.sign     (),
		.overflow (),
		.carry    ()
	);

	assign target_pc = {tgt_sum[xlen-1:1], tgt_sum[0] & ~pc_src};

endmodule

// File: rtl/operand_select.sv
module operand_select import exe_pkg::*; (
	input  logic [xlen-1:0] rs1_data,
	input  logic [xlen-1:0] rs2_data,
	input  logic [xlen-1:0] me_result,
	input  logic [xlen-1:0] wb_result,
	input  logic [xlen-1:0] pc,
	input  logic [xlen-1:0] imm,
	input  fwd_src_t        rs1_src,
	input  fwd_src_t        rs2_src,
	input  op1_sel_t        op1_sel,
	input  op2_sel_t        op2_sel,
	output logic [xlen-1:0] new_rs1,
	output logic [xlen-1:0] new_rs2,
	output logic [xlen-1:0] op1,
	output logic [xlen-1:0] op2
);

	function automatic logic [xlen-1:0] resolve(input fwd_src_t src, input logic [xlen-1:0] val);
		case (src)
			fwd_me:  return me_result;
			fwd_wb:  return wb_result;
			default: return val;
		endcase
	endfunction

	assign new_rs1 = resolve(rs1_src, rs1_data);
	assign new_rs2 = resolve(rs2_src, rs2_data);

	assign op1 = (op1_sel == op1_pc) ? pc : new_rs1;

	always_comb begin
		case (op2_sel)
			op2_imm:  op2 = imm;
			op2_four: op2 = xlen'(4);
			default:  op2 = new_rs2;
		endcase
	end

endmodule

// File: rtl/adder64.sv
module adder64 import exe_pkg::*; (
	input  logic [xlen-1:0] op1,
	input  logic [xlen-1:0] op2,
	input  logic            cin,
	output logic [xlen-1:0] result,
	output logic            zero,
	output logic            sign,
	output logic            overflow,
	output logic            carry
);

	logic cout;

	assign {cout, result} = {1'b0, op1} + {1'b0, op2} + {{xlen{1'b0}}, cin};

	assign zero = (result == '0);
	assign sign = result[xlen-1];

	// same-sign operands giving a result of the other sign
	assign overflow = (op1[xlen-1] == op2[xlen-1]) && (result[xlen-1] != op1[xlen-1]);

	// borrow of op1 - op2, read directly by sltu and bltu
	assign carry = ~cout;

endmodule

// File: rtl/wb_map_pkg.sv
package wb_map_pkg;

	// word addresses on the bus
	typedef enum logic [2:0] {
		reg_rs1_val = 3'd0,
		reg_rs2_val = 3'd1,
		reg_pc_val  = 3'd2,
		reg_imm_val = 3'd3,
		reg_cmd     = 3'd4,
		reg_result  = 3'd5,
		reg_target  = 3'd6,
		reg_flags   = 3'd7
	} wb_reg_t;

	// command word layout
	localparam int cmd_alu_op_lo  = 0;
	localparam int cmd_alu_op_hi  = 4;
	localparam int cmd_op1_sel    = 5;
	localparam int cmd_op2_sel_lo = 6;
	localparam int cmd_op2_sel_hi = 7;
	localparam int cmd_pc_src     = 8;
	localparam int cmd_rs1_lo     = 9;
	localparam int cmd_rs1_hi     = 13;
	localparam int cmd_rs2_lo     = 14;
	localparam int cmd_rs2_hi     = 18;
	localparam int cmd_rd_lo      = 19;
	localparam int cmd_rd_hi      = 23;

endpackage

// File: rtl/exe_pkg.sv
package exe_pkg;

	// datapath word width, fixed at RV64
	localparam int xlen = 64;

	// codes are stable, the command word carries them directly
	typedef enum logic [4:0] {
		alu_add  = 5'd0,
		alu_addw = 5'd1,
		alu_sub  = 5'd2,
		alu_subw = 5'd3,
		alu_slt  = 5'd4,
		alu_sltu = 5'd5,
		alu_xor  = 5'd6,
		alu_or   = 5'd7,
		alu_and  = 5'd8,
		alu_sll  = 5'd9,
		alu_srl  = 5'd10,
		alu_sra  = 5'd11,
		alu_sllw = 5'd12,
		alu_srlw = 5'd13,
		alu_sraw = 5'd14,
		alu_lui  = 5'd15,
		alu_beq  = 5'd16,
		alu_bne  = 5'd17,
		alu_blt  = 5'd18,
		alu_bge  = 5'd19,
		alu_bltu = 5'd20,
		alu_bgeu = 5'd21
	} alu_op_t;

	// source of a register operand
	typedef enum logic [1:0] {fwd_reg = 2'd0, fwd_me = 2'd1, fwd_wb = 2'd2} fwd_src_t;

	typedef enum logic {op1_rs1 = 1'b0, op1_pc = 1'b1} op1_sel_t;

	// four is the link value for jal
	typedef enum logic [1:0] {op2_rs2 = 2'd0, op2_imm = 2'd1, op2_four = 2'd2} op2_sel_t;

endpackage
